//--- design/dac_settings.svh
`ifndef DAC_SETTINGS_SVH
`define DAC_SETTINGS_SVH

////////////////////
// Board population
////////////////////

// One SPI channel per DAC chip
`define DAC_NUM_CHANNELS 8

// Bits per DAC write frame
`define DAC_WORD_BITS 24

////////////////////
// Timing
////////////////////

// System clock cycles per SCK half period
`define DAC_SCK_HALF 2

// LDAC length after reset, pulse is this plus two cycles
`define DAC_LDAC_DEFAULT 40

`endif

//--- design/dac_pkg.sv
`include "dac_settings.svh"

package dac_pkg;

    // Widths with a meaning
    typedef logic [`DAC_WORD_BITS-1:0]            dac_word_t;
    typedef logic [$clog2(`DAC_NUM_CHANNELS)-1:0] dac_chan_t;
    typedef logic [`DAC_NUM_CHANNELS-1:0]         dac_chan_mask_t;
    typedef logic [7:0]                           ldac_len_t;

    // Command opcodes, codes 5 to 7 are undefined
    typedef enum logic [2:0] {
        OP_WRITE         = 3'd0,
        OP_LDAC          = 3'd1,
        OP_SET_LDAC_LEN  = 3'd2,
        OP_READ_LDAC_LEN = 3'd3,
        OP_RESET         = 3'd4
    } dac_opcode_t;

    typedef enum logic [1:0] {
        REPLY_ACK     = 2'd0,
        REPLY_BUSY    = 2'd1,
        REPLY_UNKNOWN = 2'd2
    } dac_reply_code_t;

    typedef struct packed {
        dac_opcode_t opcode;
        dac_chan_t   chan;
        dac_word_t   data;
    } dac_cmd_t;

    typedef struct packed {
        dac_reply_code_t code;
        ldac_len_t       data;
    } dac_reply_t;

endpackage

//--- design/dac_cmd_decoder.sv
`timescale 1ns/1ps
`include "dac_settings.svh"

module dac_cmd_decoder (
    input  logic                    CLK100MHZ,
    input  logic                    rst_n,
    input  logic                    cmd_valid,
    input  dac_pkg::dac_cmd_t       cmd,
    input  dac_pkg::dac_chan_mask_t chan_busy,
    input  logic                    ldac_pending,
    output dac_pkg::dac_chan_mask_t start,
    output dac_pkg::dac_word_t      start_word,
    output logic                    abort,
    output logic                    ldac_req,
    output dac_pkg::ldac_len_t      ldac_len,
    output logic                    reply_valid,
    output dac_pkg::dac_reply_t     reply
);

    dac_pkg::dac_chan_mask_t start_next;
    dac_pkg::dac_reply_t     reply_next;
    logic                    abort_next;
    logic                    ldac_next;
    logic                    len_load;

    ////////////////////
    // Opcode decode
    ////////////////////

    always_comb begin
        start_next      = '0;
        abort_next      = 1'b0;
        ldac_next       = 1'b0;
        len_load        = 1'b0;
        reply_next.code = dac_pkg::REPLY_ACK;
        reply_next.data = '0;
        case (cmd.opcode)
            dac_pkg::OP_WRITE: begin
                // A start still in flight counts as busy
                if (chan_busy[cmd.chan] || start[cmd.chan]) begin
                    reply_next.code = dac_pkg::REPLY_BUSY;
                end else begin
                    start_next = dac_pkg::dac_chan_mask_t'(1) << cmd.chan;
                end
            end
            dac_pkg::OP_LDAC: begin
                if (ldac_pending || ldac_req) begin
                    reply_next.code = dac_pkg::REPLY_BUSY;
                end else begin
                    ldac_next = 1'b1;
                end
            end
            dac_pkg::OP_SET_LDAC_LEN: begin
                len_load = 1'b1;
            end
            dac_pkg::OP_READ_LDAC_LEN: begin
                reply_next.data = ldac_len;
            end
            dac_pkg::OP_RESET: begin
                abort_next = 1'b1;
            end
            default: begin
                reply_next.code = dac_pkg::REPLY_UNKNOWN;
            end
        endcase
    end

    ////////////////////
    // Registered pulses and reply
    ////////////////////

    always_ff @(posedge CLK100MHZ or negedge rst_n) begin
        if (!rst_n) begin
            start       <= '0;
            abort       <= 1'b0;
            ldac_req    <= 1'b0;
            reply_valid <= 1'b0;
            reply       <= '0;
            ldac_len    <= dac_pkg::ldac_len_t'(`DAC_LDAC_DEFAULT);
        end else begin
            start       <= cmd_valid ? start_next : '0;
            abort       <= cmd_valid & abort_next;
            ldac_req    <= cmd_valid & ldac_next;
            reply_valid <= cmd_valid;
            if (cmd_valid) begin
                reply <= reply_next;
            end
            // Length takes the low byte of the data field
            if (cmd_valid && len_load) begin
                ldac_len <= cmd.data[$bits(dac_pkg::ldac_len_t)-1:0];
            end
        end
    end

    // Data word goes to every channel, only the started one loads it
    always_ff @(posedge CLK100MHZ) begin
        if (cmd_valid && cmd.opcode == dac_pkg::OP_WRITE) begin
            start_word <= cmd.data;
        end
    end

endmodule

//--- design/dac_spi_channel.sv
`timescale 1ns/1ps
`include "dac_settings.svh"

module dac_spi_channel (
    input  logic               CLK100MHZ,
    input  logic               rst_n,
    input  logic               start,
    input  dac_pkg::dac_word_t word,
    input  logic               abort,
    output logic               busy,
    output logic               cs_n,
    output logic               sck,
    output logic               sdo
);

    localparam int HALF_W = $clog2(`DAC_SCK_HALF + 1);
    localparam int BIT_W  = $clog2(`DAC_WORD_BITS);
    localparam int MSB    = `DAC_WORD_BITS - 1;

    localparam logic [HALF_W-1:0] HALF_LAST = HALF_W'(`DAC_SCK_HALF - 1);
    localparam logic [BIT_W-1:0]  LAST_BIT  = BIT_W'(`DAC_WORD_BITS - 1);

    typedef enum logic [1:0] {
        IDLE,
        SHIFT,
        FINISH
    } spi_state_t;

    spi_state_t         state;
    logic [HALF_W-1:0]  half_cnt;
    logic [BIT_W-1:0]   bit_cnt;
    dac_pkg::dac_word_t shreg;
    logic               half_tick;
    logic               shift_now;

    assign half_tick = (half_cnt == HALF_LAST);
    // Falling SCK moves the next bit onto sdo
    assign shift_now = (state == SHIFT) && half_tick && sck;
    assign busy      = (state != IDLE);

    always_ff @(posedge CLK100MHZ or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            half_cnt <= '0;
            bit_cnt  <= '0;
            cs_n     <= 1'b1;
            sck      <= 1'b0;
            sdo      <= 1'b0;
        end else if (abort) begin
            state <= IDLE;
            cs_n  <= 1'b1;
            sck   <= 1'b0;
            sdo   <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (start) begin
                        state    <= SHIFT;
                        cs_n     <= 1'b0;
                        sdo      <= word[MSB];
                        half_cnt <= '0;
                        bit_cnt  <= '0;
                    end
                end
                SHIFT: begin
                    if (!half_tick) begin
                        half_cnt <= half_cnt + 1'b1;
                    end else begin
                        half_cnt <= '0;
                        sck      <= ~sck;
                        if (sck && bit_cnt == LAST_BIT) begin
                            // Last bit sampled, park sdo before cs_n rises
                            sdo   <= 1'b0;
                            state <= FINISH;
                        end else if (sck) begin
                            bit_cnt <= bit_cnt + 1'b1;
                            sdo     <= shreg[MSB-1];
                        end
                    end
                end
                FINISH: begin
                    cs_n  <= 1'b1;
                    state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK100MHZ) begin
        if (state == IDLE && start) begin
            shreg <= word;
        end else if (shift_now) begin
            shreg <= shreg << 1;
        end
    end

endmodule

//--- design/dac_ldac_pulser.sv
`timescale 1ns/1ps

module dac_ldac_pulser (
    input  logic                    CLK100MHZ,
    input  logic                    rst_n,
    input  logic                    ldac_req,
    input  dac_pkg::ldac_len_t      ldac_len,
    input  dac_pkg::dac_chan_mask_t chan_busy,
    input  logic                    abort,
    output logic                    ldac_pending,
    output logic                    ldac_n
);

    localparam int CNT_W = $bits(dac_pkg::ldac_len_t) + 1;

    typedef enum logic [1:0] {
        IDLE,
        WAIT_IDLE,
        PULSE
    } ldac_state_t;

    ldac_state_t        state;
    dac_pkg::ldac_len_t len_q;
    logic [CNT_W-1:0]   cnt;

    assign ldac_pending = (state != IDLE);

    ////////////////////
    // Pulse FSM
    ////////////////////

    always_ff @(posedge CLK100MHZ or negedge rst_n) begin
        if (!rst_n) begin
            state  <= IDLE;
            cnt    <= '0;
            ldac_n <= 1'b1;
        end else if (abort) begin
            state  <= IDLE;
            ldac_n <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    if (ldac_req) begin
                        state <= WAIT_IDLE;
                    end
                end
                WAIT_IDLE: begin
                    // Hold off until no chip select is active
                    if (chan_busy == '0) begin
                        ldac_n <= 1'b0;
                        cnt    <= {1'b0, len_q} + 1'b1;
                        state  <= PULSE;
                    end
                end
                PULSE: begin
                    if (cnt == '0) begin
                        ldac_n <= 1'b1;
                        state  <= IDLE;
                    end else begin
                        cnt <= cnt - 1'b1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Length is frozen at request time
    always_ff @(posedge CLK100MHZ) begin
        if (state == IDLE && ldac_req) begin
            len_q <= ldac_len;
        end
    end

endmodule

//--- design/dac_controller_top.sv
`timescale 1ns/1ps
`include "dac_settings.svh"

module dac_controller_top (
    input  logic                    CLK100MHZ,
    input  logic                    rst_n,
    input  logic                    cmd_valid,
    input  dac_pkg::dac_cmd_t       cmd,
    output logic                    reply_valid,
    output dac_pkg::dac_reply_t     reply,
    output dac_pkg::dac_chan_mask_t cs_n,
    output dac_pkg::dac_chan_mask_t sck,
    output dac_pkg::dac_chan_mask_t sdo,
    output logic                    ldac_n
);

    dac_pkg::dac_chan_mask_t start;
    dac_pkg::dac_word_t      start_word;
    dac_pkg::dac_chan_mask_t chan_busy;
    dac_pkg::ldac_len_t      ldac_len;
    logic                    abort;
    logic                    ldac_req;
    logic                    ldac_pending;

    dac_cmd_decoder i_decoder (
        .CLK100MHZ    (CLK100MHZ),
        .rst_n        (rst_n),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .chan_busy    (chan_busy),
        .ldac_pending (ldac_pending),
        .start        (start),
        .start_word   (start_word),
        .abort        (abort),
        .ldac_req     (ldac_req),
        .ldac_len     (ldac_len),
        .reply_valid  (reply_valid),
        .reply        (reply)
    );

    // One serializer per DAC chip
    for (genvar i = 0; i < `DAC_NUM_CHANNELS; i++) begin : g_chan
        dac_spi_channel i_chan (
            .CLK100MHZ (CLK100MHZ),
            .rst_n     (rst_n),
            .start     (start[i]),
            .word      (start_word),
            .abort     (abort),
            .busy      (chan_busy[i]),
            .cs_n      (cs_n[i]),
            .sck       (sck[i]),
            .sdo       (sdo[i])
        );
    end

    dac_ldac_pulser i_pulser (
        .CLK100MHZ    (CLK100MHZ),
        .rst_n        (rst_n),
        .ldac_req     (ldac_req),
        .ldac_len     (ldac_len),
        .chan_busy    (chan_busy),
        .abort        (abort),
        .ldac_pending (ldac_pending),
        .ldac_n       (ldac_n)
    );

endmodule

//--- verification/dac_controller_assert.sv
`timescale 1ns/1ps

module dac_controller_assert (
    input logic                    CLK100MHZ,
    input logic                    rst_n,
    input logic                    reply_valid,
    input dac_pkg::dac_chan_mask_t cs_n,
    input dac_pkg::dac_chan_mask_t sck,
    input dac_pkg::dac_chan_mask_t sdo,
    input logic                    ldac_n
);

    // Set by any failed property
    logic property_failed = 1'b0;

    // Every reply is a single cycle strobe
    a_reply_single: assert property (
        @(posedge CLK100MHZ) disable iff (!rst_n)
        reply_valid |=> !reply_valid
    ) else begin
        $error("reply_valid stayed high for two cycles");
        property_failed = 1'b1;
    end

    // No load pulse while any DAC is selected
    a_ldac_idle: assert property (
        @(posedge CLK100MHZ) disable iff (!rst_n)
        !ldac_n |-> (cs_n == '1)
    ) else begin
        $error("ldac_n low while a chip select is active");
        property_failed = 1'b1;
    end

    a_serial_parked: assert property (
        @(posedge CLK100MHZ) disable iff (!rst_n)
        ((sck | sdo) & cs_n) == '0
    ) else begin
        $error("sck or sdo active on a deselected channel");
        property_failed = 1'b1;
    end

endmodule

bind dac_controller_top dac_controller_assert i_assert (
    .CLK100MHZ   (CLK100MHZ),
    .rst_n       (rst_n),
    .reply_valid (reply_valid),
    .cs_n        (cs_n),
    .sck         (sck),
    .sdo         (sdo),
    .ldac_n      (ldac_n)
);

//--- verification/dac_controller_tb.sv
`timescale 1ns/1ps
`include "dac_settings.svh"

module dac_controller_tb;

    localparam int WAIT_LIMIT = 400;

    logic                    CLK100MHZ;
    logic                    rst_n;
    logic                    cmd_valid;
    dac_pkg::dac_cmd_t       cmd;
    logic                    reply_valid;
    dac_pkg::dac_reply_t     reply;
    dac_pkg::dac_chan_mask_t cs_n;
    dac_pkg::dac_chan_mask_t sck;
    dac_pkg::dac_chan_mask_t sdo;
    logic                    ldac_n;

    dac_controller_top i_dut (
        .CLK100MHZ   (CLK100MHZ),
        .rst_n       (rst_n),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .reply_valid (reply_valid),
        .reply       (reply),
        .cs_n        (cs_n),
        .sck         (sck),
        .sdo         (sdo),
        .ldac_n      (ldac_n)
    );

    initial begin
        CLK100MHZ = 1'b0;
        forever #5 CLK100MHZ = ~CLK100MHZ;
    end

    ////////////////////
    // Failure reporting
    ////////////////////

    task automatic end_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped after a failed check");
    endtask

    task automatic report_mismatch(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        end_with_failure();
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out at %0t ns while waiting for %s", $time, what);
        end_with_failure();
    endtask

    // Protocol properties of the bound checker
    always @(posedge i_dut.i_assert.property_failed) begin
        $display("A protocol property of the DUT failed at %0t ns", $time);
        end_with_failure();
    end

    ////////////////////
    // Bus and pin helpers
    ////////////////////

    task automatic next_cycle();
        @(posedge CLK100MHZ);
        #1;
    endtask

    // Drive one command strobe and wait for its reply strobe
    task automatic send_cmd(input logic [2:0] op, input int ch,
                            input dac_pkg::dac_word_t data, output dac_pkg::dac_reply_t rep);
        int cycles;
        cycles = 0;
        next_cycle();
        cmd_valid  = 1'b1;
        cmd.opcode = dac_pkg::dac_opcode_t'(op);
        cmd.chan   = dac_pkg::dac_chan_t'(ch);
        cmd.data   = data;
        next_cycle();
        cmd_valid = 1'b0;
        while (reply_valid !== 1'b1 && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (reply_valid !== 1'b1) report_timeout("the reply strobe");
        rep = reply;
    endtask

    task automatic expect_reply(input dac_pkg::dac_reply_t rep,
                                input dac_pkg::dac_reply_code_t code,
                                input dac_pkg::ldac_len_t data, input string what);
        assert (rep.code == code && rep.data == data)
        else report_mismatch($sformatf("%s: reply code %0d data %0d, expected %0d data %0d",
                                       what, rep.code, rep.data, code, data));
    endtask

    task automatic wait_cs_level(input int ch, input logic level, input int limit);
        int cycles;
        cycles = 0;
        while (cs_n[ch] !== level && cycles < limit) begin
            next_cycle();
            cycles++;
        end
        if (cs_n[ch] !== level) report_timeout($sformatf("cs_n[%0d] to go %0b", ch, level));
    endtask

    // Receiver model sampling sdo on each rising sck while cs_n is low
    task automatic capture_word(input int ch, output dac_pkg::dac_word_t word,
                                output int nbits);
        int   cycles;
        logic prev_sck;
        word   = '0;
        nbits  = 0;
        cycles = 0;
        wait_cs_level(ch, 1'b0, WAIT_LIMIT);
        prev_sck = sck[ch];
        while (cs_n[ch] === 1'b0 && cycles < WAIT_LIMIT) begin
            if (!prev_sck && sck[ch]) begin
                word = {word[`DAC_WORD_BITS-2:0], sdo[ch]};
                nbits++;
            end
            assert ((cs_n | (dac_pkg::dac_chan_mask_t'(1) << ch)) == '1)
            else report_mismatch($sformatf("other chip select low during channel %0d", ch));
            prev_sck = sck[ch];
            next_cycle();
            cycles++;
        end
        if (cs_n[ch] === 1'b0) report_timeout($sformatf("cs_n[%0d] to rise", ch));
    endtask

    task automatic measure_ldac(output int low_cycles);
        int cycles;
        cycles     = 0;
        low_cycles = 0;
        while (ldac_n !== 1'b0 && cycles < WAIT_LIMIT) begin
            next_cycle();
            cycles++;
        end
        if (ldac_n !== 1'b0) report_timeout("ldac_n to fall");
        while (ldac_n === 1'b0 && low_cycles < WAIT_LIMIT) begin
            low_cycles++;
            next_cycle();
        end
        if (ldac_n === 1'b0) report_timeout("ldac_n to rise");
    endtask

    ////////////////////
    // Directed tests
    ////////////////////

    task automatic check_reset_state();
        dac_pkg::dac_reply_t rep;
        assert (cs_n === '1 && ldac_n === 1'b1 && sck === '0 && sdo === '0)
        else report_mismatch("pins not at their idle levels after reset");
        send_cmd(dac_pkg::OP_READ_LDAC_LEN, 0, '0, rep);
        expect_reply(rep, dac_pkg::REPLY_ACK, 8'd40, "read default LDAC length");
    endtask

    task automatic write_every_channel();
        dac_pkg::dac_reply_t rep;
        dac_pkg::dac_word_t  word;
        dac_pkg::dac_word_t  got;
        int                  nbits;
        for (int ch = 0; ch < `DAC_NUM_CHANNELS; ch++) begin
            word = dac_pkg::dac_word_t'($urandom);
            send_cmd(dac_pkg::OP_WRITE, ch, word, rep);
            expect_reply(rep, dac_pkg::REPLY_ACK, '0, "write");
            capture_word(ch, got, nbits);
            assert (nbits == `DAC_WORD_BITS && got == word)
            else report_mismatch($sformatf("channel %0d sent %0d bits %h, expected %h",
                                           ch, nbits, got, word));
        end
    endtask

    task automatic refuse_busy_write();
        dac_pkg::dac_reply_t rep;
        dac_pkg::dac_reply_t rep_busy;
        dac_pkg::dac_word_t  first;
        dac_pkg::dac_word_t  second;
        dac_pkg::dac_word_t  got;
        int                  nbits;
        first  = dac_pkg::dac_word_t'($urandom);
        second = ~first;
        send_cmd(dac_pkg::OP_WRITE, 3, first, rep);
        expect_reply(rep, dac_pkg::REPLY_ACK, '0, "first write");
        fork
            capture_word(3, got, nbits);
            begin
                wait_cs_level(3, 1'b0, WAIT_LIMIT);
                send_cmd(dac_pkg::OP_WRITE, 3, second, rep_busy);
            end
        join
        expect_reply(rep_busy, dac_pkg::REPLY_BUSY, '0, "write to busy channel");
        assert (nbits == `DAC_WORD_BITS && got == first)
        else report_mismatch($sformatf("captured %h, expected first word %h", got, first));
    endtask

    task automatic pulse_ldac();
        dac_pkg::dac_reply_t rep;
        int                  low_cycles;
        int                  cycles;
        send_cmd(dac_pkg::OP_SET_LDAC_LEN, 0, 24'd5, rep);
        expect_reply(rep, dac_pkg::REPLY_ACK, '0, "set LDAC length");
        send_cmd(dac_pkg::OP_READ_LDAC_LEN, 0, '0, rep);
        expect_reply(rep, dac_pkg::REPLY_ACK, 8'd5, "read LDAC length");
        send_cmd(dac_pkg::OP_LDAC, 0, '0, rep);
        expect_reply(rep, dac_pkg::REPLY_ACK, '0, "LDAC");
        measure_ldac(low_cycles);
        assert (low_cycles == 7)
        else report_mismatch($sformatf("ldac_n low %0d cycles, expected 7", low_cycles));
        // LDAC requested in the middle of a transfer
        send_cmd(dac_pkg::OP_WRITE, 2, dac_pkg::dac_word_t'($urandom), rep);
        expect_reply(rep, dac_pkg::REPLY_ACK, '0, "write before LDAC");
        wait_cs_level(2, 1'b0, WAIT_LIMIT);
        send_cmd(dac_pkg::OP_LDAC, 0, '0, rep);
        expect_reply(rep, dac_pkg::REPLY_ACK, '0, "LDAC during write");
        cycles = 0;
        while (cs_n[2] === 1'b0 && cycles < WAIT_LIMIT) begin
            assert (ldac_n === 1'b1)
            else report_mismatch("ldac_n fell while cs_n[2] was low");
            next_cycle();
            cycles++;
        end
        if (cs_n[2] === 1'b0) report_timeout("cs_n[2] to rise");
        measure_ldac(low_cycles);
        assert (low_cycles == 7)
        else report_mismatch($sformatf("ldac_n low %0d cycles, expected 7", low_cycles));
    endtask

    task automatic abort_and_unknown();
        dac_pkg::dac_reply_t rep;
        send_cmd(dac_pkg::OP_WRITE, 5, dac_pkg::dac_word_t'($urandom), rep);
        expect_reply(rep, dac_pkg::REPLY_ACK, '0, "write before reset");
        wait_cs_level(5, 1'b0, WAIT_LIMIT);
        repeat (10) next_cycle();
        send_cmd(dac_pkg::OP_RESET, 0, '0, rep);
        expect_reply(rep, dac_pkg::REPLY_ACK, '0, "reset command");
        wait_cs_level(5, 1'b1, 4);
        send_cmd(3'd6, 0, '0, rep);
        expect_reply(rep, dac_pkg::REPLY_UNKNOWN, '0, "undefined opcode");
    endtask

    initial begin
        void'($urandom(32'h380ca861));
        rst_n     = 1'b0;
        cmd_valid = 1'b0;
        cmd       = '0;
        repeat (4) @(posedge CLK100MHZ);
        #1;
        rst_n = 1'b1;
        next_cycle();
        check_reset_state();
        write_every_channel();
        refuse_busy_write();
        pulse_ldac();
        abort_and_unknown();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+design
design/dac_pkg.sv
design/dac_cmd_decoder.sv
design/dac_spi_channel.sv
design/dac_ldac_pulser.sv
design/dac_controller_top.sv
verification/dac_controller_assert.sv
verification/dac_controller_tb.sv
